// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_sifh_top
FILELIST  ?= sifh.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  := FAIL: see errors above

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	    echo "simulation failed"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/hist_bank_ram.sv
module hist_bank_ram import sifh_pkg::*; #(
    parameter int BIN_W     = 6,
    parameter int PIXEL_NUM = 200
) (
    input  logic   clk,
    input  logic   res,
    input  logic   inc_en,
    input  bank_t  inc_bank,
    input  pixel_t inc_pixel,
    input  bin_t   inc_bin,
    input  logic   rd_en,
    input  bank_t  rd_bank,
    input  pixel_t rd_pixel,
    input  bin_t   rd_bin,
    output count_t rd_count,
    output logic   clear_done
);

    localparam int BINS       = 2 ** BIN_W;
    localparam int BANK_WORDS = PIXEL_NUM * BINS;
    localparam int DEPTH      = 2 * BANK_WORDS;
    localparam int AW         = $clog2(DEPTH);

    typedef logic [AW-1:0] addr_t;

    // both banks, bank 1 in the upper half
    count_t mem [DEPTH];

    // increment stage, read done, write-back pending
    logic   s1_valid;
    addr_t  s1_addr;
    count_t s1_count;
    count_t s1_next;

    // clear-on-read, one cycle behind the read
    logic  clr_valid;
    addr_t clr_addr;

    // post-reset sweep
    addr_t sweep_addr;

    addr_t inc_addr;
    addr_t rd_addr;

    // bank, pixel, bin -> flat address
    function automatic addr_t loc(input bank_t b, input pixel_t p, input bin_t n);
        int idx;
        idx = int'(b) * BANK_WORDS + int'(p) * BINS + int'(n[BIN_W-1:0]);
        return addr_t'(idx);
    endfunction

    assign inc_addr = loc(inc_bank, inc_pixel, inc_bin);
    assign rd_addr  = loc(rd_bank, rd_pixel, rd_bin);
    assign s1_next  = s1_count + count_t'(1);

    // valid bits and sweeper
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_valid   <= 1'b0;
            clr_valid  <= 1'b0;
            sweep_addr <= '0;
            clear_done <= 1'b0;
        end else begin
            s1_valid  <= inc_en;
            clr_valid <= rd_en;
            if (!clear_done) begin
                if (sweep_addr == addr_t'(DEPTH - 1)) begin
                    clear_done <= 1'b1;
                end else begin
                    sweep_addr <= sweep_addr + 1'b1;
                end
            end
        end
    end

    // read side of both ports
    // a hit on the location in write-back takes the new value
    always_ff @(posedge clk) begin
        if (inc_en) begin
            s1_addr <= inc_addr;
            if (s1_valid && (s1_addr == inc_addr)) begin
                s1_count <= s1_next;
            end else begin
                s1_count <= mem[inc_addr];
            end
        end
        if (rd_en) begin
            clr_addr <= rd_addr;
            if (s1_valid && (s1_addr == rd_addr)) begin
                rd_count <= s1_next;
            end else begin
                rd_count <= mem[rd_addr];
            end
        end
    end

    // write side, sweep only runs before any traffic
    always_ff @(posedge clk) begin
        if (!clear_done) begin
            mem[sweep_addr] <= '0;
        end
        if (s1_valid) begin
            mem[s1_addr] <= s1_next;
        end
        if (clr_valid) begin
            mem[clr_addr] <= '0;
        end
    end

endmodule

// File: hdl/hist_builder.sv
module hist_builder import sifh_pkg::*; #(
    parameter int BIN_W     = 6,
    parameter int DATA_NUM  = 2,
    parameter int PIXEL_NUM = 200,
    parameter int ACQ_NUM   = 1000
) (
    input  logic   clk,
    input  logic   res,
    input  logic   sample_en,
    input  bin_t   sample_bin,
    output logic   sample_ready,
    output logic   inc_en,
    output bank_t  inc_bank,
    output pixel_t inc_pixel,
    output bin_t   inc_bin,
    output logic   set_done,
    input  logic   bank_busy,
    input  logic   clear_done
);

    // counter widths, +1 keeps a count of one legal
    localparam int DW  = $clog2(DATA_NUM + 1);
    localparam int AQW = $clog2(ACQ_NUM + 1);

    builder_state_e state;

    // nested position of the next sample
    logic [DW-1:0]  data_cnt;
    pixel_t         pixel_cnt;
    logic [AQW-1:0] acq_cnt;

    // bank currently being filled
    bank_t bank_sel;

    logic accept;
    logic data_last;
    logic pixel_last;
    logic acq_last;
    logic set_last;

    // no samples during set_done, bank_sel toggles at its end
    assign sample_ready = (state == COUNTING) && !set_done;
    assign accept       = sample_en && sample_ready;

    assign data_last  = (data_cnt == DW'(DATA_NUM - 1));
    assign pixel_last = (pixel_cnt == pixel_t'(PIXEL_NUM - 1));
    assign acq_last   = (acq_cnt == AQW'(ACQ_NUM - 1));

    // final sample of the whole set
    assign set_last = accept && data_last && pixel_last && acq_last;

    // control state, counters and bank toggle
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= IDLE_CLEAR;
            data_cnt  <= '0;
            pixel_cnt <= '0;
            acq_cnt   <= '0;
            bank_sel  <= 1'b0;
            set_done  <= 1'b0;
            inc_en    <= 1'b0;
        end else begin
            // one increment command per accepted sample
            inc_en   <= accept;
            set_done <= 1'b0;

            // filled bank handed over, start the next one
            if (set_done) begin
                bank_sel <= ~bank_sel;
            end

            // sample -> pixel -> acquisition carry chain
            if (accept) begin
                if (data_last) begin
                    data_cnt <= '0;
                    if (pixel_last) begin
                        pixel_cnt <= '0;
                        if (acq_last) begin
                            acq_cnt <= '0;
                        end else begin
                            acq_cnt <= acq_cnt + 1'b1;
                        end
                    end else begin
                        pixel_cnt <= pixel_cnt + 1'b1;
                    end
                end else begin
                    data_cnt <= data_cnt + 1'b1;
                end
            end

            case (state)
                IDLE_CLEAR: begin
                    if (clear_done) begin
                        state <= COUNTING;
                    end
                end
                COUNTING: begin
                    // previous set still draining -> stall
                    if (set_last) begin
                        if (bank_busy) begin
                            state <= WAIT_BANK;
                        end else begin
                            set_done <= 1'b1;
                        end
                    end
                end
                WAIT_BANK: begin
                    if (!bank_busy) begin
                        set_done <= 1'b1;
                        state    <= COUNTING;
                    end
                end
                default: begin
                    state <= IDLE_CLEAR;
                end
            endcase
        end
    end

    // increment address, captured with the sample
    // inc_bank keeps the filled bank until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            inc_bank  <= bank_sel;
            inc_pixel <= pixel_cnt;
            inc_bin   <= bin_t'(sample_bin[BIN_W-1:0]);
        end
    end

endmodule

// File: hdl/hist_readout.sv
module hist_readout import sifh_pkg::*; #(
    parameter int BIN_W     = 6,
    parameter int PIXEL_NUM = 200
) (
    input  logic       clk,
    input  logic       res,
    input  logic       set_done,
    input  bank_t      done_bank,
    output logic       bank_busy,
    output logic       rd_en,
    output bank_t      rd_bank,
    output pixel_t     rd_pixel,
    output bin_t       rd_bin,
    input  count_t     rd_count,
    output logic       out_req,
    output hist_word_t out_word,
    input  logic       out_ack
);

    localparam int BINS = 2 ** BIN_W;

    typedef enum logic [2:0] {
        RO_IDLE,
        // read issued to memory
        RO_READ,
        // count arriving, load word
        RO_LOAD,
        // req high, waiting for ack
        RO_REQ,
        // req low, waiting for ack to drop
        RO_ACK_LOW
    } readout_state_e;

    readout_state_e state;

    logic bin_last;
    logic word_last;

    assign bin_last  = (rd_bin == bin_t'(BINS - 1));
    assign word_last = bin_last && (rd_pixel == pixel_t'(PIXEL_NUM - 1));

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= RO_IDLE;
            bank_busy <= 1'b0;
            rd_en     <= 1'b0;
            rd_bank   <= 1'b0;
            rd_pixel  <= '0;
            rd_bin    <= '0;
            out_req   <= 1'b0;
        end else begin
            case (state)
                RO_IDLE: begin
                    // take over the bank, first read right away
                    if (set_done) begin
                        bank_busy <= 1'b1;
                        rd_bank   <= done_bank;
                        rd_pixel  <= '0;
                        rd_bin    <= '0;
                        rd_en     <= 1'b1;
                        state     <= RO_READ;
                    end
                end
                RO_READ: begin
                    rd_en <= 1'b0;
                    state <= RO_LOAD;
                end
                RO_LOAD: begin
                    out_req <= 1'b1;
                    state   <= RO_REQ;
                end
                RO_REQ: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= RO_ACK_LOW;
                    end
                end
                RO_ACK_LOW: begin
                    // handshake closed, next bin or release
                    if (!out_ack) begin
                        if (word_last) begin
                            bank_busy <= 1'b0;
                            state     <= RO_IDLE;
                        end else begin
                            if (bin_last) begin
                                rd_bin   <= '0;
                                rd_pixel <= rd_pixel + 1'b1;
                            end else begin
                                rd_bin <= rd_bin + 1'b1;
                            end
                            rd_en <= 1'b1;
                            state <= RO_READ;
                        end
                    end
                end
                default: begin
                    state <= RO_IDLE;
                end
            endcase
        end
    end

    // word held from load until the next load, stable through req/ack
    always_ff @(posedge clk) begin
        if (state == RO_LOAD) begin
            out_word <= '{pixel: rd_pixel, bin: rd_bin, count: rd_count};
        end
    end

endmodule

// File: hdl/sifh_pkg.sv
package sifh_pkg;

    // width of one bin counter
    // must hold DATA_NUM * ACQ_NUM hits
    localparam int COUNT_W = 16;

    // raw field widths of sample and readout word
    localparam int BIN_BITS   = 8;
    localparam int PIXEL_BITS = 8;

    // time-bin index of a sample
    // only the low BIN_W bits address the histogram
    typedef logic [BIN_BITS-1:0] bin_t;

    // pixel index inside one acquisition
    typedef logic [PIXEL_BITS-1:0] pixel_t;

    // hits collected in one bin
    typedef logic [COUNT_W-1:0] count_t;

    // histogram bank select, ping-pong between fill and drain
    typedef logic bank_t;

    // readout payload, pixel in the top byte
    typedef struct packed {
        pixel_t pixel;
        bin_t   bin;
        count_t count;
    } hist_word_t;

    // builder control
    typedef enum logic [1:0] {
        // memory sweep after reset still running
        IDLE_CLEAR,
        // samples accepted and counted
        COUNTING,
        // set complete, other bank not yet drained
        WAIT_BANK
    } builder_state_e;

endpackage

// File: hdl/sifh_top.sv
module sifh_top import sifh_pkg::*; #(
    parameter int BIN_W     = 6,
    parameter int DATA_NUM  = 2,
    parameter int PIXEL_NUM = 200,
    parameter int ACQ_NUM   = 1000
) (
    input  logic       clk,
    input  logic       res,
    input  logic       sample_en,
    input  bin_t       sample_bin,
    output logic       sample_ready,
    output logic       out_req,
    output hist_word_t out_word,
    input  logic       out_ack
);

    // builder -> memory
    logic   inc_en;
    bank_t  inc_bank;
    pixel_t inc_pixel;
    bin_t   inc_bin;

    // builder <-> readout
    logic set_done;
    logic bank_busy;

    // memory -> builder
    logic clear_done;

    // readout <-> memory
    logic   rd_en;
    bank_t  rd_bank;
    pixel_t rd_pixel;
    bin_t   rd_bin;
    count_t rd_count;

    hist_builder #(
        .BIN_W     (BIN_W),
        .DATA_NUM  (DATA_NUM),
        .PIXEL_NUM (PIXEL_NUM),
        .ACQ_NUM   (ACQ_NUM)
    ) hist_builder_i (
        .clk          (clk),
        .res          (res),
        .sample_en    (sample_en),
        .sample_bin   (sample_bin),
        .sample_ready (sample_ready),
        .inc_en       (inc_en),
        .inc_bank     (inc_bank),
        .inc_pixel    (inc_pixel),
        .inc_bin      (inc_bin),
        .set_done     (set_done),
        .bank_busy    (bank_busy),
        .clear_done   (clear_done)
    );

    hist_bank_ram #(
        .BIN_W     (BIN_W),
        .PIXEL_NUM (PIXEL_NUM)
    ) hist_bank_ram_i (
        .clk        (clk),
        .res        (res),
        .inc_en     (inc_en),
        .inc_bank   (inc_bank),
        .inc_pixel  (inc_pixel),
        .inc_bin    (inc_bin),
        .rd_en      (rd_en),
        .rd_bank    (rd_bank),
        .rd_pixel   (rd_pixel),
        .rd_bin     (rd_bin),
        .rd_count   (rd_count),
        .clear_done (clear_done)
    );

    // inc_bank still names the filled bank while set_done is high
    hist_readout #(
        .BIN_W     (BIN_W),
        .PIXEL_NUM (PIXEL_NUM)
    ) hist_readout_i (
        .clk       (clk),
        .res       (res),
        .set_done  (set_done),
        .done_bank (inc_bank),
        .bank_busy (bank_busy),
        .rd_en     (rd_en),
        .rd_bank   (rd_bank),
        .rd_pixel  (rd_pixel),
        .rd_bin    (rd_bin),
        .rd_count  (rd_count),
        .out_req   (out_req),
        .out_word  (out_word),
        .out_ack   (out_ack)
    );

endmodule

// File: sifh.f
hdl/sifh_pkg.sv
hdl/hist_builder.sv
hdl/hist_bank_ram.sv
hdl/hist_readout.sv
hdl/sifh_top.sv
test/sifh_properties.sv
test/tb_sifh_top.sv

// File: test/sifh_properties.sv
module sifh_properties import sifh_pkg::*; (
    input logic       clk,
    input logic       res,
    input logic       sample_ready,
    input logic       set_done,
    input logic       bank_busy,
    input logic       out_req,
    input hist_word_t out_word,
    input logic       out_ack
);
    timeunit 1ns;
    timeprecision 1ps;

    // failed assertions so far
    int unsigned fails = 0;

    // req held until the consumer answers
    req_hold_a: assert property (@(posedge clk) disable iff (!res)
        out_req && !out_ack |=> out_req)
        else begin
            fails++;
            $error("out_req dropped before out_ack was seen");
        end

    // payload frozen while req is up
    word_stable_a: assert property (@(posedge clk) disable iff (!res)
        out_req && $past(out_req) |-> $stable(out_word))
        else begin
            fails++;
            $error("out_word changed while out_req was high");
        end

    // ack seen, req must fall
    req_fall_a: assert property (@(posedge clk) disable iff (!res)
        out_req && out_ack |=> !out_req)
        else begin
            fails++;
            $error("out_req stayed high after out_ack");
        end

    // no new req while the old ack is still high
    req_rise_a: assert property (@(posedge clk) disable iff (!res)
        !out_req && out_ack |=> !out_req)
        else begin
            fails++;
            $error("out_req rose while out_ack was still high");
        end

    // stalled builder stays stalled while the other bank drains
    stall_a: assert property (@(posedge clk) disable iff (!res)
        !sample_ready && bank_busy |=> !sample_ready)
        else begin
            fails++;
            $error("sample_ready rose while the readout still held the other bank");
        end

    // bank handed over only to an idle readout
    handover_a: assert property (@(posedge clk) disable iff (!res)
        set_done |-> !bank_busy)
        else begin
            fails++;
            $error("set_done raised while the readout was still busy");
        end

endmodule

// readout side, no sample port here
bind hist_readout sifh_properties link_props_i (
    .clk          (clk),
    .res          (res),
    .sample_ready (1'b1),
    .set_done     (set_done),
    .bank_busy    (bank_busy),
    .out_req      (out_req),
    .out_word     (out_word),
    .out_ack      (out_ack)
);

// builder side, no readout link here
bind hist_builder sifh_properties stall_props_i (
    .clk          (clk),
    .res          (res),
    .sample_ready (sample_ready),
    .set_done     (set_done),
    .bank_busy    (bank_busy),
    .out_req      (1'b0),
    .out_word     ('0),
    .out_ack      (1'b0)
);

// File: test/tb_sifh_top.sv
module tb_sifh_top import sifh_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BIN_W       = 3;
    localparam int DATA_NUM    = 4;
    localparam int PIXEL_NUM   = 2;
    localparam int ACQ_NUM     = 3;
    localparam int SETS        = 3;
    localparam int BINS        = 2 ** BIN_W;
    localparam int WORDS       = PIXEL_NUM * BINS;
    localparam int SET_SAMPLES = DATA_NUM * PIXEL_NUM * ACQ_NUM;
    localparam int CLEAR_CYC   = 2 * WORDS;
    localparam int RESET_CYC   = 16;
    localparam int TIMEOUT_CYC =
        RESET_CYC + 4 * (CLEAR_CYC + SETS * (SET_SAMPLES + 8 * WORDS));

    logic       clk;
    logic       res;
    logic       sample_en;
    bin_t       sample_bin;
    logic       sample_ready;
    logic       out_req;
    hist_word_t out_word;
    logic       out_ack;

    // reference counts per set, pixel and bin
    int   expected [SETS][PIXEL_NUM][BINS];
    int   accepted;
    int   received;
    int   errors;
    int   cycles;
    int   ready_wait;
    logic ready_seen;

    sifh_top #(
        .BIN_W     (BIN_W),
        .DATA_NUM  (DATA_NUM),
        .PIXEL_NUM (PIXEL_NUM),
        .ACQ_NUM   (ACQ_NUM)
    ) sifh_top_i (
        .clk          (clk),
        .res          (res),
        .sample_en    (sample_en),
        .sample_bin   (sample_bin),
        .sample_ready (sample_ready),
        .out_req      (out_req),
        .out_word     (out_word),
        .out_ack      (out_ack)
    );

    always #10 clk = ~clk;

    // model side of every accepted sample
    always @(posedge clk) begin
        int set_idx;
        int pixel;
        if (res && sample_en && sample_ready) begin
            set_idx = accepted / SET_SAMPLES;
            // position inside the acquisition picks the pixel
            pixel = (accepted % (DATA_NUM * PIXEL_NUM)) / DATA_NUM;
            if (set_idx < SETS) begin
                expected[set_idx][pixel][int'(sample_bin[BIN_W-1:0])]++;
            end
            accepted++;
        end
    end

    // no sample taken before both banks are cleared
    always @(posedge clk) begin
        if (res && !ready_seen) begin
            if (sample_ready) begin
                ready_seen = 1'b1;
                assert (ready_wait >= CLEAR_CYC) else begin
                    errors++;
                    $display("sample_ready rose %0d cycles after reset, before the clear",
                             ready_wait);
                end
            end else begin
                ready_wait++;
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYC) begin
            $display("timeout after %0d cycles, %0d of %0d words, %0d errors",
                     cycles, received, SETS * WORDS, errors);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // words come pixel-major, bins ascending
    task automatic check_word(input hist_word_t w);
        int set_idx;
        int pixel;
        int bin;
        set_idx = received / WORDS;
        pixel   = (received % WORDS) / BINS;
        bin     = received % BINS;
        assert (set_idx < SETS) else begin
            errors++;
            $display("word received after all %0d sets were drained", SETS);
        end
        assert (accepted >= (set_idx + 1) * SET_SAMPLES) else begin
            errors++;
            $display("word received before its set was complete");
        end
        assert (w.pixel == pixel_t'(pixel)) else begin
            errors++;
            $display("[ERROR] out_word.pixel = 0x%h, expected 0x%h", w.pixel, pixel_t'(pixel));
        end
        assert (w.bin == bin_t'(bin)) else begin
            errors++;
            $display("[ERROR] out_word.bin = 0x%h, expected 0x%h", w.bin, bin_t'(bin));
        end
        if (set_idx < SETS) begin
            assert (w.count == count_t'(expected[set_idx][pixel][bin])) else begin
                errors++;
                $display("[ERROR] out_word.count = 0x%h, expected 0x%h at pixel %0d bin %0d",
                         w.count, count_t'(expected[set_idx][pixel][bin]), pixel, bin);
            end
        end
        received++;
    endtask

    // hold the sample until the builder takes it
    task automatic send_sample(input bin_t b);
        sample_en  <= 1'b1;
        sample_bin <= b;
        @(posedge clk);
        while (!sample_ready) begin
            @(posedge clk);
        end
    endtask

    task automatic report_result();
        int prop_fails;
        prop_fails = sifh_top_i.hist_readout_i.link_props_i.fails
                   + sifh_top_i.hist_builder_i.stall_props_i.fails;
        $display("errors: %0d check, %0d property", errors, prop_fails);
        if (errors == 0 && prop_fails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // slow consumer, random delay in both phases
    initial begin
        forever begin
            @(posedge clk);
            if (out_req) begin
                wait_cycles($urandom_range(0, 5));
                check_word(out_word);
                out_ack <= 1'b1;
                do begin
                    @(posedge clk);
                end while (out_req);
                wait_cycles($urandom_range(0, 5));
                out_ack <= 1'b0;
            end
        end
    end

    initial begin
        bin_t bin;
        clk        = 1'b0;
        res        = 1'b0;
        sample_en  = 1'b0;
        sample_bin = '0;
        out_ack    = 1'b0;
        ready_seen = 1'b0;
        bin        = '0;
        void'($urandom(55));
        repeat (RESET_CYC) @(posedge clk);
        res <= 1'b1;
        for (int i = 0; i < SETS * SET_SAMPLES; i++) begin
            // opening run of one bin, later runs at random
            if (i == 0 || (i >= 4 && $urandom_range(0, 2) != 0)) begin
                bin = bin_t'($urandom);
            end
            if ($urandom_range(0, 7) == 0) begin
                sample_en <= 1'b0;
                @(posedge clk);
            end
            send_sample(bin);
        end
        sample_en <= 1'b0;
        wait (received == SETS * WORDS);
        wait_cycles(20);
        report_result();
    end

endmodule
